// ==== verilog.f ====
+incdir+source
source/decode_pkg.sv
source/bundle_fifo.sv
source/inst_decoder.sv
source/id_reg.sv
source/decode_stage_top.sv
bench/tb_decode_stage.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module tb_decode_stage \
		-f verilog.f -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_decode_stage); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf obj_dir

// ==== bench/tb_decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module tb_decode_stage;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 5;

    logic                      aclk = 1'b0;
    logic                      reset;
    logic                      flush;
    logic                      fetch_valid;
    logic                      fetch_ready;
    decode_pkg::fetch_pair_t   fetch_pair;
    logic                      iq_valid;
    logic                      iq_ready;
    decode_pkg::issue_bundle_t iq_bundle;
    logic [31:0]               rnd = 32'h48405c7c;
    int                        errors = 0;
    int                        tests_run = 0;
    int                        tests_failed = 0;

    decode_stage_top u_dut (
        .aclk        (aclk),
        .reset       (reset),
        .flush       (flush),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_pair  (fetch_pair),
        .iq_valid    (iq_valid),
        .iq_ready    (iq_ready),
        .iq_bundle   (iq_bundle)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected slot from the intended uop and the fixed field bit ranges.
    function automatic decode_pkg::slot_uop_t exp_slot(input decode_pkg::uop_e u,
                                                       input logic [31:0] inst,
                                                       input logic [31:0] imm);
        decode_pkg::slot_uop_t s;
        s            = '0;
        s.uop        = u;
        s.imm        = imm;
        s.rd         = inst[4:0];
        s.rj         = inst[9:5];
        s.rk         = inst[14:10];
        s.is_alu     = u inside {decode_pkg::uop_add, decode_pkg::uop_sub,
                                 decode_pkg::uop_addi, decode_pkg::uop_lu12i};
        s.is_branch  = u inside {decode_pkg::uop_beq, decode_pkg::uop_bne, decode_pkg::uop_b};
        s.is_syscall = (u == decode_pkg::uop_syscall);
        s.is_break   = (u == decode_pkg::uop_brk);
        s.is_priv    = (u == decode_pkg::uop_csrrd);
        return s;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    // tasks start and end 1 ns after a rising edge.
    task automatic push_pair(input logic [31:0] pc, input logic [31:0] i0, input logic [31:0] i1,
                             input logic s1v, input logic [6:0] fexc);
        int waited;
        waited = 0;
        while (!fetch_ready && waited < 50) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        if (!fetch_ready) begin
            $display("fetch_ready stayed low, the pair at pc %h was never accepted", pc);
            errors++;
        end else begin
            fetch_pair.pc0             = pc;
            fetch_pair.inst0           = i0;
            fetch_pair.inst1           = i1;
            fetch_pair.slot1_valid     = s1v;
            fetch_pair.fetch_exception = fexc;
            fetch_valid                = 1'b1;
            @(posedge aclk);
            #1;
            fetch_valid = 1'b0;
        end
    endtask

    task automatic pop_bundle(output decode_pkg::issue_bundle_t b, output logic ok);
        int waited;
        waited = 0;
        while (!iq_valid && waited < 50) begin
            @(posedge aclk);
            #1;
            waited++;
        end
        ok = iq_valid;
        b  = iq_bundle;
        if (!ok) begin
            $display("no bundle reached the issue queue within 50 cycles");
            errors++;
        end else begin
            iq_ready = 1'b1;
            @(posedge aclk);
            #1;
            iq_ready = 1'b0;
        end
    endtask

    task automatic run_pair(input logic [31:0] pc, input logic [31:0] i0, input logic [31:0] i1,
                            input logic s1v, input logic [6:0] fexc,
                            input decode_pkg::slot_uop_t e0, input decode_pkg::slot_uop_t e1,
                            input logic [1:0] eflag, input logic [6:0] eexc);
        decode_pkg::issue_bundle_t b;
        logic                      ok;
        push_pair(pc, i0, i1, s1v, fexc);
        pop_bundle(b, ok);
        if (ok) begin
            check_val("pc0", 64'(b.pc0), 64'(pc));
            check_val("inst0", 64'(b.inst0), 64'(i0));
            check_val("inst1", 64'(b.inst1), 64'(i1));
            check_val("slot1_valid", 64'(b.slot1_valid), 64'(s1v));
            check_val("slot0", 64'(b.slot0), 64'(e0));
            check_val("slot1", 64'(b.slot1), 64'(e1));
            check_val("excp_flag", 64'(b.excp_flag), 64'(eflag));
            check_val("exception", 64'(b.exception), 64'(eexc));
        end
    endtask

    task automatic test_basic();
        int          e;
        logic [31:0] r0, ia, ib;
        e = errors;
        check_val("iq_valid", 64'(iq_valid), 64'(0));
        check_val("fetch_ready", 64'(fetch_ready), 64'(1));
        check_val("id_reg out_valid", 64'(u_dut.u_id_reg.out_valid), 64'(0));
        rnd = xorshift(rnd);
        r0  = rnd;
        ia  = {17'h00020, r0[14:0]};
        ib  = {10'h00a, r0[31:20], r0[9:5], r0[4:0] ^ 5'h0f};  // rd differs from ia.
        run_pair(32'h0000_0040, ia, ib, 1'b1, 7'd0,
                 exp_slot(decode_pkg::uop_add, ia, 32'd0),
                 exp_slot(decode_pkg::uop_addi, ib, {{20{r0[31]}}, r0[31:20]}), 2'b00, 7'd0);
        repeat (4) @(posedge aclk);
        #1;
        check_val("iq_valid", 64'(iq_valid), 64'(0));  // exactly one bundle.
        finish_test("reset_and_basic", e);
    endtask

    task automatic test_immediates();
        int          e;
        logic [31:0] r0, r1, ia, ib;
        e   = errors;
        rnd = xorshift(rnd);
        r0  = rnd;
        rnd = xorshift(rnd);
        r1  = rnd;
        ia  = {7'h0a, r0[24:0]};
        ib  = {10'h0a2, r1[21:0]};
        run_pair(32'h0000_0100, ia, ib, 1'b1, 7'd0,
                 exp_slot(decode_pkg::uop_lu12i, ia, {r0[24:5], 12'b0}),
                 exp_slot(decode_pkg::uop_ld, ib, {{20{r1[21]}}, r1[21:10]}), 2'b00, 7'd0);
        ia = {10'h0a6, r1[31:10]};
        ib = {6'h16, r0[25:0]};
        run_pair(32'h0000_0108, ia, ib, 1'b1, 7'd0,
                 exp_slot(decode_pkg::uop_st, ia, {{20{r1[31]}}, r1[31:20]}),
                 exp_slot(decode_pkg::uop_beq, ib, {{14{r0[25]}}, r0[25:10], 2'b00}),
                 2'b00, 7'd0);
        ia = {6'h17, r1[25:0]};
        ib = {6'h14, r0[15:0], r0[25:16]};  // offs26 high bits sit in 9:0.
        run_pair(32'h0000_0110, ia, ib, 1'b1, 7'd0,
                 exp_slot(decode_pkg::uop_bne, ia, {{14{r1[25]}}, r1[25:10], 2'b00}),
                 exp_slot(decode_pkg::uop_b, ib, {{4{r0[25]}}, r0[25:0], 2'b00}), 2'b00, 7'd0);
        finish_test("immediates", e);
    endtask

    task automatic test_exceptions();
        int          e;
        logic [31:0] add_i, bad_i, sys_i, brk_i, csr_i;
        e     = errors;
        add_i = {17'h00020, 5'd3, 5'd2, 5'd1};
        bad_i = 32'hffff_ffff;
        sys_i = {17'h00056, 15'h0012};
        brk_i = {17'h00054, 15'h0003};
        csr_i = {8'h04, 14'h0005, 5'd0, 5'd7};
        run_pair(32'h0000_0200, add_i, bad_i, 1'b1, 7'd0,
                 exp_slot(decode_pkg::uop_add, add_i, 32'd0),
                 exp_slot(decode_pkg::uop_nop, bad_i, 32'd0), 2'b10, `DEC_EXP_INE);
        run_pair(32'h0000_0208, add_i, bad_i, 1'b1, 7'h08,
                 exp_slot(decode_pkg::uop_add, add_i, 32'd0),
                 exp_slot(decode_pkg::uop_nop, bad_i, 32'd0), 2'b11, 7'h08);
        run_pair(32'h0000_0210, sys_i, brk_i, 1'b1, 7'd0,
                 exp_slot(decode_pkg::uop_syscall, sys_i, 32'd0),
                 exp_slot(decode_pkg::uop_brk, brk_i, 32'd0), 2'b00, 7'd0);
        run_pair(32'h0000_0218, csr_i, bad_i, 1'b0, 7'd0,
                 exp_slot(decode_pkg::uop_csrrd, csr_i, 32'd0), '0, 2'b00, 7'd0);
        finish_test("exceptions", e);
    endtask

    task automatic test_backpressure();
        int                        e;
        int                        pushed;
        decode_pkg::issue_bundle_t b;
        logic                      ok;
        e      = errors;
        pushed = 0;
        while (fetch_ready && pushed < 20) begin
            push_pair(32'h0000_1000 + 32'(pushed * 8), {17'h00020, 15'(pushed)}, 32'd0,
                      1'b0, 7'd0);
            pushed++;
        end
        check_val("held_pairs", 64'(pushed), 64'(`DEC_FETCH_DEPTH + 1 + `DEC_ISSUE_DEPTH));
        for (int k = 0; k < pushed; k++) begin
            pop_bundle(b, ok);
            if (ok) begin
                check_val("pc0", 64'(b.pc0), 64'(32'h0000_1000 + 32'(k * 8)));
            end
        end
        repeat (2) @(posedge aclk);
        #1;
        check_val("iq_valid", 64'(iq_valid), 64'(0));
        finish_test("backpressure", e);
    endtask

    task automatic test_flush();
        int          e;
        logic [31:0] sub_i;
        e     = errors;
        sub_i = {17'h00022, 5'd9, 5'd8, 5'd4};
        // fill the issue queue, id_reg and the fetch buffer.
        for (int k = 0; k < `DEC_FETCH_DEPTH + 1 + `DEC_ISSUE_DEPTH; k++) begin
            push_pair(32'h0000_2000 + 32'(k * 8), sub_i, sub_i, 1'b1, 7'd0);
        end
        @(posedge aclk);
        #1;
        flush = 1'b1;
        @(posedge aclk);
        #1;
        flush = 1'b0;
        check_val("iq_valid", 64'(iq_valid), 64'(0));
        check_val("fetch_ready", 64'(fetch_ready), 64'(1));
        run_pair(32'h0000_3000, sub_i, sub_i, 1'b1, 7'd0,
                 exp_slot(decode_pkg::uop_sub, sub_i, 32'd0),
                 exp_slot(decode_pkg::uop_sub, sub_i, 32'd0), 2'b00, 7'd0);
        repeat (4) @(posedge aclk);
        #1;
        check_val("iq_valid", 64'(iq_valid), 64'(0));
        finish_test("flush", e);
    endtask

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", NUM_TESTS * 200);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pair  = '0;
        iq_ready    = 1'b0;
        repeat (10) @(posedge aclk);
        #1;
        reset = 1'b0;
        test_basic();
        test_immediates();
        test_exceptions();
        test_backpressure();
        test_flush();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== source/decode_stage_top.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module decode_stage_top (
    input  logic                      aclk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    input  decode_pkg::fetch_pair_t   fetch_pair,
    output logic                      iq_valid,
    input  logic                      iq_ready,
    output decode_pkg::issue_bundle_t iq_bundle
);

    decode_pkg::fetch_pair_t   head_pair;
    decode_pkg::slot_dec_t     dec [2];
    logic [31:0]               head_inst [2];
    logic                      fetch_full;
    logic                      fetch_empty;
    logic                      id_in_ready;
    logic                      id_out_valid;
    decode_pkg::issue_bundle_t id_out_bundle;
    logic                      iq_full;
    logic                      iq_empty;

    assign fetch_ready  = ~fetch_full;
    assign iq_valid     = ~iq_empty;
    assign head_inst[0] = head_pair.inst0;
    assign head_inst[1] = head_pair.inst1;

    bundle_fifo #(.payload_t(decode_pkg::fetch_pair_t), .DEPTH(`DEC_FETCH_DEPTH)) u_fetch_buf (
        .aclk      (aclk),
        .reset     (reset),
        .flush     (flush),
        .push      (fetch_valid & ~fetch_full),
        .push_data (fetch_pair),
        .full      (fetch_full),
        .pop       (~fetch_empty & id_in_ready),  // popped in the cycle id_reg loads.
        .pop_data  (head_pair),
        .empty     (fetch_empty)
    );

    for (genvar i = 0; i < 2; i++) begin : g_dec
        inst_decoder u_dec (
            .inst (head_inst[i]),
            .dec  (dec[i])
        );
    end

    id_reg u_id_reg (
        .aclk       (aclk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (~fetch_empty),
        .in_ready   (id_in_ready),
        .fetch_in   (head_pair),
        .dec0       (dec[0]),
        .dec1       (dec[1]),
        .out_valid  (id_out_valid),
        .out_ready  (~iq_full),
        .out_bundle (id_out_bundle)
    );

    bundle_fifo #(.payload_t(decode_pkg::issue_bundle_t), .DEPTH(`DEC_ISSUE_DEPTH)) u_issue_q (
        .aclk      (aclk),
        .reset     (reset),
        .flush     (flush),
        .push      (id_out_valid & ~iq_full),
        .push_data (id_out_bundle),
        .full      (iq_full),
        .pop       (iq_ready & ~iq_empty),
        .pop_data  (iq_bundle),
        .empty     (iq_empty)
    );

endmodule

// ==== source/id_reg.sv ====
`timescale 1ns/1ps
`include "decode_defines.svh"

module id_reg (
    input  logic                      aclk,
    input  logic                      reset,
    input  logic                      flush,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  decode_pkg::fetch_pair_t   fetch_in,
    input  decode_pkg::slot_dec_t     dec0,
    input  decode_pkg::slot_dec_t     dec1,
    output logic                      out_valid,
    input  logic                      out_ready,
    output decode_pkg::issue_bundle_t out_bundle
);

    logic                      valid_q;
    decode_pkg::issue_bundle_t bundle_q;
    decode_pkg::issue_bundle_t bundle_d;
    logic                      inv0;
    logic                      inv1;
    logic                      fetch_excp;

    function automatic decode_pkg::slot_uop_t strip_slot(input decode_pkg::slot_dec_t d);
        decode_pkg::slot_uop_t s;
        s.uop        = d.uop;
        s.imm        = d.imm;
        s.rd         = d.rd;
        s.rj         = d.rj;
        s.rk         = d.rk;
        s.is_alu     = d.is_alu;
        s.is_branch  = d.is_branch;
        s.is_syscall = d.is_syscall;
        s.is_break   = d.is_break;
        s.is_priv    = d.is_priv;
        return s;
    endfunction

    assign inv0       = dec0.invalid;
    assign inv1       = dec1.invalid & fetch_in.slot1_valid;  // empty slot 1 never faults.
    assign fetch_excp = (fetch_in.fetch_exception != 7'd0);

    always_comb begin
        bundle_d             = '0;
        bundle_d.pc0         = fetch_in.pc0;
        bundle_d.inst0       = fetch_in.inst0;
        bundle_d.inst1       = fetch_in.inst1;
        bundle_d.slot1_valid = fetch_in.slot1_valid;
        bundle_d.slot0       = strip_slot(dec0);
        bundle_d.slot1       = fetch_in.slot1_valid ? strip_slot(dec1) : '0;
        bundle_d.excp_flag   = fetch_excp ? 2'b11 : {inv1, inv0};
        // fetch fault wins over decode fault.
        bundle_d.exception   = fetch_excp ? fetch_in.fetch_exception :
                               (inv0 | inv1) ? `DEC_EXP_INE : 7'd0;
    end

    // full register takes a new pair while handing its bundle on.
    assign in_ready   = ~valid_q | out_ready;
    assign out_valid  = valid_q;
    assign out_bundle = bundle_q;

    always_ff @(posedge aclk) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_valid && in_ready) begin
            bundle_q <= bundle_d;
        end
    end

    a_hold_stable: assert property (@(posedge aclk) disable iff (reset || flush)
        (out_valid && !out_ready) |=> $stable(out_bundle));

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
    input  logic [31:0]           inst,
    output decode_pkg::slot_dec_t dec
);

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [7:0]  op8;
    logic [6:0]  op7;
    logic [5:0]  op6;
    logic [31:0] imm_si12;
    logic [31:0] imm_si20;
    logic [31:0] imm_offs16;
    logic [31:0] imm_offs26;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op8  = inst[31:24];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];

    assign imm_si12   = {{20{inst[21]}}, inst[21:10]};
    assign imm_si20   = {inst[24:5], 12'b0};
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    // offs26 keeps its high ten bits in 9:0.
    assign imm_offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        dec     = '0;
        dec.uop = decode_pkg::uop_nop;
        dec.rd  = inst[4:0];  // register fields are taken for every format.
        dec.rj  = inst[9:5];
        dec.rk  = inst[14:10];
        if (op17 == 17'h00020) begin
            dec.uop    = decode_pkg::uop_add;
            dec.is_alu = 1'b1;
        end else if (op17 == 17'h00022) begin
            dec.uop    = decode_pkg::uop_sub;
            dec.is_alu = 1'b1;
        end else if (op17 == 17'h00056) begin
            dec.uop        = decode_pkg::uop_syscall;
            dec.is_syscall = 1'b1;
        end else if (op17 == 17'h00054) begin
            dec.uop      = decode_pkg::uop_brk;
            dec.is_break = 1'b1;
        end else if (op10 == 10'h00a) begin
            dec.uop    = decode_pkg::uop_addi;
            dec.imm    = imm_si12;
            dec.is_alu = 1'b1;
        end else if (op7 == 7'h0a) begin
            dec.uop    = decode_pkg::uop_lu12i;
            dec.imm    = imm_si20;
            dec.is_alu = 1'b1;
        end else if (op10 == 10'h0a2) begin
            dec.uop = decode_pkg::uop_ld;
            dec.imm = imm_si12;
        end else if (op10 == 10'h0a6) begin
            dec.uop = decode_pkg::uop_st;
            dec.imm = imm_si12;
        end else if (op6 == 6'h16) begin
            dec.uop       = decode_pkg::uop_beq;
            dec.imm       = imm_offs16;
            dec.is_branch = 1'b1;
        end else if (op6 == 6'h17) begin
            dec.uop       = decode_pkg::uop_bne;
            dec.imm       = imm_offs16;
            dec.is_branch = 1'b1;
        end else if (op6 == 6'h14) begin
            dec.uop       = decode_pkg::uop_b;
            dec.imm       = imm_offs26;
            dec.is_branch = 1'b1;
        end else if (op8 == 8'h04 && inst[9:5] == 5'd0) begin
            // rj of one or more selects csrwr or csrxchg.
            dec.uop     = decode_pkg::uop_csrrd;
            dec.is_priv = 1'b1;
        end else begin
            dec.invalid = 1'b1;
        end
    end

endmodule

// ==== source/bundle_fifo.sv ====
`timescale 1ns/1ps

module bundle_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     aclk,
    input  logic     reset,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    output logic     full,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push & ~full;
    assign do_pop   = pop & ~empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

    // producers must watch full and consumers empty.
    a_no_push_full: assert property (@(posedge aclk) disable iff (reset)
        full |-> !push);
    a_no_pop_empty: assert property (@(posedge aclk) disable iff (reset)
        empty |-> !pop);

endmodule

// ==== source/decode_pkg.sv ====
`include "decode_defines.svh"

package decode_pkg;

    typedef enum logic [`DEC_UOP_W-1:0] {
        uop_nop,
        uop_add,
        uop_sub,
        uop_addi,
        uop_lu12i,
        uop_ld,
        uop_st,
        uop_beq,
        uop_bne,
        uop_b,
        uop_syscall,
        uop_brk,
        uop_csrrd
    } uop_e;

    // pc1 is pc0 + 4 and is not stored.
    typedef struct packed {
        logic [31:0] pc0;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic        slot1_valid;
        logic [6:0]  fetch_exception;  // zero means none.
    } fetch_pair_t;

    typedef struct packed {
        uop_e        uop;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        is_alu;
        logic        is_branch;
        logic        is_syscall;
        logic        is_break;
        logic        is_priv;
        logic        invalid;
    } slot_dec_t;

    // slot as held in the issue queue, invalid is folded into excp_flag.
    typedef struct packed {
        uop_e        uop;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic        is_alu;
        logic        is_branch;
        logic        is_syscall;
        logic        is_break;
        logic        is_priv;
    } slot_uop_t;

    typedef struct packed {
        logic [31:0] pc0;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic        slot1_valid;
        slot_uop_t   slot0;
        slot_uop_t   slot1;
        logic [1:0]  excp_flag;
        logic [6:0]  exception;
    } issue_bundle_t;

endpackage

// ==== source/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// fetch buffer entries, one instruction pair each.
`define DEC_FETCH_DEPTH 4

// issue queue entries, one decoded bundle each.
`define DEC_ISSUE_DEPTH 4

// width of the uop enumeration.
`define DEC_UOP_W 5

// instruction-not-exist exception code.
`define DEC_EXP_INE 7'h0d

`endif
